//--- hw/l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;

	// ------------------------------
	// geometry
	// ------------------------------
	localparam int WORD_ADDR_W = 12;                     // word address
	localparam int WORD_W      = 32;
	localparam int BLOCK_W     = 2;
	localparam int BLOCK_WORDS = 1 << BLOCK_W;           // words per block
	localparam int SET_W       = 2;
	localparam int N_SETS      = 1 << SET_W;
	localparam int N_WAYS      = 2;
	localparam int WAY_W       = 1;
	localparam int TAG_W       = WORD_ADDR_W - SET_W - BLOCK_W;
	localparam int LINE_W      = SET_W + WAY_W;          // {set, way}
	localparam int N_LINES     = 1 << LINE_W;
	localparam int RAM_ADDR_W  = LINE_W + BLOCK_W;       // {set, way, beat}

	// ------------------------------
	// vector types
	// ------------------------------
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;
	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [TAG_W-1:0]       tag_t;
	typedef logic [SET_W-1:0]       set_idx_t;
	typedef logic [WAY_W-1:0]       way_t;
	typedef logic [LINE_W-1:0]      line_idx_t;
	typedef logic [BLOCK_W-1:0]     beat_t;
	typedef logic [RAM_ADDR_W-1:0]  ram_addr_t;

	// l1 request, rw=1 means l1 hands a block down
	typedef struct packed {
		word_addr_t addr;
		logic       rw;
	} l1_cmd_t;

	// block command to memory
	typedef struct packed {
		logic       block;
		logic       rw;        // 1 = block write (writeback)
		word_addr_t addr;      // block aligned
	} mem_cmd_t;

	typedef struct packed {
		logic hit;
		logic miss;
		logic writeback;
	} perf_t;

	typedef enum logic [2:0] {
		ST_NORMAL       = 3'd0,   // hit/miss check
		ST_WAIT_READY   = 3'd1,   // wait for memory, issue fill
		ST_WRITE_BUFFER = 3'd2,   // victim line to writeback buffer
		ST_READ_BUFFER  = 3'd3,   // fill line from memory or l1
		ST_READ_FROM_L1 = 3'd4,   // write hit, l1 block into ram
		ST_WRITE_TO_L1  = 3'd5,   // read hit, stream block up
		ST_TAG_WAIT     = 3'd6
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/l2_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module l2_tag_store (
	input  wire                     clock_i,
	input  wire                     resetn_i,
	input  wire l2_cache_pkg::set_idx_t set_i,
	input  wire l2_cache_pkg::tag_t     tag_i,        // lookup and write tag
	input  wire                     wren_i,
	input  wire l2_cache_pkg::way_t     wr_way_i,
	input  wire l2_cache_pkg::way_t     victim_way_i,
	output logic                    hit_o,
	output l2_cache_pkg::way_t      hit_way_o,
	output l2_cache_pkg::tag_t      victim_tag_o
);

	l2_cache_pkg::tag_t                tag_q [l2_cache_pkg::N_LINES];
	logic [l2_cache_pkg::N_LINES-1:0]  valid_q;
	l2_cache_pkg::line_idx_t           wr_line;
	l2_cache_pkg::line_idx_t           probe_line;

	assign wr_line = {set_i, wr_way_i};

	// valid bits, only control state here
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (wren_i) begin
			valid_q[wr_line] <= 1'b1;             // line now holds a block
		end
	end

	// tag array
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tag_q[wr_line] <= tag_i;
		end
	end

	// ------------------------------
	// lookup across both ways
	// ------------------------------
	always_comb begin
		hit_o      = 1'b0;
		hit_way_o  = '0;
		probe_line = '0;
		for (int w = 0; w < l2_cache_pkg::N_WAYS; w++) begin
			probe_line = {set_i, l2_cache_pkg::way_t'(w)};
			if (valid_q[probe_line] && (tag_q[probe_line] == tag_i)) begin
				hit_o     = 1'b1;
				hit_way_o = l2_cache_pkg::way_t'(w);
			end
		end
	end

	// tag of the line about to be replaced, for the writeback address
	assign victim_tag_o = tag_q[{set_i, victim_way_i}];

endmodule

`default_nettype wire

//--- hw/l2_data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module l2_data_ram (
	input  wire                         clock_i,
	input  wire l2_cache_pkg::ram_addr_t addr_i,   // {set, way, beat}
	input  wire                         wren_i,
	input  wire l2_cache_pkg::word_t     wdata_i,
	output l2_cache_pkg::word_t          rdata_o
);

	localparam int DEPTH = 1 << l2_cache_pkg::RAM_ADDR_W;

	// ------------------------------
	// storage
	// ------------------------------
	l2_cache_pkg::word_t mem_q [DEPTH];

	// write port
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			mem_q[addr_i] <= wdata_i;
		end
	end

	// read port, one cycle latency, old data on same-address write
	always_ff @(posedge clock_i) begin
		rdata_o <= mem_q[addr_i];
	end

endmodule

`default_nettype wire

//--- hw/l2_fifo_replacement.sv
`timescale 1ns/100ps
`default_nettype none

module l2_fifo_replacement (
	input  wire                         clock_i,
	input  wire                         resetn_i,
	input  wire l2_cache_pkg::set_idx_t set_i,       // set being looked up
	input  wire                         advance_i,   // fill committed
	input  wire l2_cache_pkg::set_idx_t adv_set_i,
	output l2_cache_pkg::way_t          victim_way_o
);

	// round robin pointer per set
	l2_cache_pkg::way_t ptr_q [l2_cache_pkg::N_SETS];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < l2_cache_pkg::N_SETS; s++) begin
				ptr_q[s] <= '0;                      // first fill goes to way 0
			end
		end else if (advance_i) begin
			if (ptr_q[adv_set_i] == l2_cache_pkg::way_t'(l2_cache_pkg::N_WAYS - 1)) begin
				ptr_q[adv_set_i] <= '0;               // wrap
			end else begin
				ptr_q[adv_set_i] <= ptr_q[adv_set_i] + 1'b1;
			end
		end
	end

	// oldest fill in the set is the victim
	assign victim_way_o = ptr_q[set_i];

endmodule

`default_nettype wire

//--- hw/l2_cache_controller.sv
`timescale 1ns/100ps
`default_nettype none

module l2_cache_controller (
	input  wire                          clock_i,
	input  wire                          resetn_i,

	// l1 side
	input  wire                          l1_req_i,
	input  wire l2_cache_pkg::l1_cmd_t   l1_cmd_i,
	input  wire                          l1_wvalid_i,
	input  wire l2_cache_pkg::word_t     l1_wdata_i,
	input  wire                          l1_rready_i,
	output logic                         l1_rack_o,
	output logic                         l1_rvalid_o,
	output logic                         l1_done_o,

	// tag store and replacement
	input  wire                          tag_hit_i,
	input  wire l2_cache_pkg::way_t      tag_hit_way_i,
	input  wire l2_cache_pkg::tag_t      victim_tag_i,
	input  wire l2_cache_pkg::way_t      victim_way_i,
	output l2_cache_pkg::set_idx_t       tag_set_o,
	output l2_cache_pkg::tag_t           tag_o,
	output logic                         tag_wren_o,
	output l2_cache_pkg::way_t           tag_way_o,
	output logic                         repl_adv_o,

	// data ram
	output l2_cache_pkg::ram_addr_t      ram_addr_o,
	output logic                         ram_wren_o,
	output l2_cache_pkg::word_t          ram_wdata_o,
	input  wire l2_cache_pkg::word_t     ram_rdata_i,

	// memory buffers and command
	input  wire                          fill_ready_i,
	input  wire l2_cache_pkg::word_t     fill_data_i,
	output logic                         fill_ack_o,
	input  wire                          wb_ready_i,
	output logic                         wb_ack_o,
	output l2_cache_pkg::word_t          wb_data_o,
	input  wire                          mem_ready_i,
	output logic                         mem_req_o,
	output l2_cache_pkg::mem_cmd_t       mem_cmd_o,

	output l2_cache_pkg::perf_t          perf_o
);

	l2_cache_pkg::ctrl_state_e           state_q;
	l2_cache_pkg::beat_t                 beat_q;      // word within block
	l2_cache_pkg::l1_cmd_t               req_q;       // request being served
	l2_cache_pkg::way_t                  way_q;       // hit way or victim
	logic                                pend_q;      // read miss, serve hit after fill
	logic                                done_q;
	logic                                rvalid_q;
	logic [l2_cache_pkg::N_LINES-1:0]    dirty_q;
	logic                                wb_pend_q;   // block write still to be issued
	l2_cache_pkg::word_addr_t            wb_addr_q;
	l2_cache_pkg::perf_t                 perf_q;

	l2_cache_pkg::l1_cmd_t               cur_cmd;
	l2_cache_pkg::set_idx_t              cur_set;
	l2_cache_pkg::line_idx_t             line;
	l2_cache_pkg::line_idx_t             hit_line;
	l2_cache_pkg::beat_t                 rd_beat;
	l2_cache_pkg::word_addr_t            fill_addr;
	logic                                active;
	logic                                last_beat;
	logic                                l1_take;
	logic                                fill_take;
	logic                                wb_push;
	logic                                commit;
	logic                                mem_go;
	logic                                issue_fill;
	logic                                issue_wb;

	// ------------------------------
	// lookup address and strobes
	// ------------------------------
	// new requests look up straight from the l1 port
	assign cur_cmd   = (state_q == l2_cache_pkg::ST_NORMAL && !pend_q) ? l1_cmd_i : req_q;
	assign cur_set   = cur_cmd.addr[l2_cache_pkg::BLOCK_W +: l2_cache_pkg::SET_W];
	assign line      = {cur_set, way_q};
	assign hit_line  = {cur_set, tag_hit_way_i};
	assign last_beat = (beat_q == l2_cache_pkg::beat_t'(l2_cache_pkg::BLOCK_WORDS - 1));
	assign active    = (state_q == l2_cache_pkg::ST_NORMAL) && (pend_q || (l1_req_i && done_q));

	assign l1_take   = l1_wvalid_i && ((state_q == l2_cache_pkg::ST_READ_FROM_L1) ||
	                   (state_q == l2_cache_pkg::ST_READ_BUFFER && req_q.rw));
	assign fill_take = fill_ready_i && (state_q == l2_cache_pkg::ST_READ_BUFFER) && !req_q.rw;
	assign wb_push   = wb_ready_i && (state_q == l2_cache_pkg::ST_WRITE_BUFFER);
	assign commit    = (l1_take || fill_take) && (state_q == l2_cache_pkg::ST_READ_BUFFER) &&
	                   last_beat;                  // last word of a fill

	// pending writeback goes out first, fill waits for it
	assign issue_wb   = wb_pend_q && mem_ready_i;
	assign mem_go     = (state_q == l2_cache_pkg::ST_WAIT_READY) && mem_ready_i && !wb_pend_q;
	assign issue_fill = mem_go && !req_q.rw;        // write miss allocates without fetch
	assign fill_addr  = {req_q.addr[l2_cache_pkg::WORD_ADDR_W-1:l2_cache_pkg::BLOCK_W],
	                     {l2_cache_pkg::BLOCK_W{1'b0}}};

	// victim read runs one word ahead of the push (ram latency)
	assign rd_beat = wb_push ? beat_q + 1'b1 : beat_q;

	// ------------------------------
	// outputs
	// ------------------------------
	assign tag_set_o   = cur_set;
	assign tag_o       = cur_cmd.addr[l2_cache_pkg::WORD_ADDR_W-1 -: l2_cache_pkg::TAG_W];
	assign tag_wren_o  = commit;
	assign tag_way_o   = way_q;
	assign repl_adv_o  = commit;                    // fifo order follows fill order

	assign ram_addr_o  = {line, rd_beat};
	assign ram_wren_o  = l1_take || fill_take;
	assign ram_wdata_o = fill_take ? fill_data_i : l1_wdata_i;

	assign l1_rack_o   = l1_take;
	assign l1_rvalid_o = rvalid_q;                  // data from ram this cycle
	assign l1_done_o   = done_q;
	assign fill_ack_o  = fill_take;
	assign wb_ack_o    = wb_push;
	assign wb_data_o   = ram_rdata_i;

	assign mem_req_o       = issue_wb || issue_fill;
	assign mem_cmd_o.block = 1'b1;
	assign mem_cmd_o.rw    = wb_pend_q;
	assign mem_cmd_o.addr  = wb_pend_q ? wb_addr_q : fill_addr;
	assign perf_o          = perf_q;

	// ------------------------------
	// state machine
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q   <= l2_cache_pkg::ST_NORMAL;
			beat_q    <= '0;
			pend_q    <= 1'b0;
			done_q    <= 1'b1;                  // ready out of reset
			rvalid_q  <= 1'b0;
			dirty_q   <= '0;
			wb_pend_q <= 1'b0;
			perf_q    <= '0;
		end else begin
			rvalid_q <= 1'b0;
			perf_q   <= '0;
			if (issue_wb) begin
				wb_pend_q <= 1'b0;
			end

			case (state_q)
				l2_cache_pkg::ST_NORMAL: begin
					if (active) begin
						done_q <= 1'b0;             // stall l1
						beat_q <= '0;
						if (tag_hit_i) begin
							pend_q      <= 1'b0;
							perf_q.hit  <= !pend_q;  // not counted on return from miss
							if (cur_cmd.rw) begin
								dirty_q[hit_line] <= 1'b1;
								state_q           <= l2_cache_pkg::ST_READ_FROM_L1;
							end else begin
								state_q <= l2_cache_pkg::ST_WRITE_TO_L1;
							end
						end else begin
							perf_q.miss <= 1'b1;
							pend_q      <= !cur_cmd.rw;
							state_q     <= l2_cache_pkg::ST_WAIT_READY;
						end
					end
				end

				l2_cache_pkg::ST_WAIT_READY: begin
					if (mem_go) begin
						if (dirty_q[line]) begin
							perf_q.writeback <= 1'b1;
							state_q          <= l2_cache_pkg::ST_WRITE_BUFFER;
						end else begin
							state_q <= l2_cache_pkg::ST_READ_BUFFER;
						end
					end
				end

				l2_cache_pkg::ST_WRITE_BUFFER: begin
					if (wb_push) begin
						if (beat_q == '0) begin
							wb_pend_q <= 1'b1;          // command after first word
						end
						beat_q <= beat_q + 1'b1;        // wraps to 0 on last
						if (last_beat) begin
							state_q <= l2_cache_pkg::ST_READ_BUFFER;
						end
					end
				end

				l2_cache_pkg::ST_READ_BUFFER: begin
					if (l1_take || fill_take) begin
						beat_q <= beat_q + 1'b1;
						if (last_beat) begin
							dirty_q[line] <= req_q.rw;  // l1 block differs from memory
							state_q       <= l2_cache_pkg::ST_TAG_WAIT;
						end
					end
				end

				l2_cache_pkg::ST_READ_FROM_L1: begin
					if (l1_take) begin
						beat_q <= beat_q + 1'b1;
						if (last_beat) begin
							done_q  <= 1'b1;
							state_q <= l2_cache_pkg::ST_NORMAL;
						end
					end
				end

				l2_cache_pkg::ST_WRITE_TO_L1: begin
					if (l1_rready_i) begin
						rvalid_q <= 1'b1;
						beat_q   <= beat_q + 1'b1;
						if (last_beat) begin
							state_q <= l2_cache_pkg::ST_TAG_WAIT;   // let last word out
						end
					end
				end

				l2_cache_pkg::ST_TAG_WAIT: begin
					done_q  <= !pend_q;          // read miss still owes the hit
					state_q <= l2_cache_pkg::ST_NORMAL;
				end

				default: begin
					state_q <= l2_cache_pkg::ST_NORMAL;
				end
			endcase
		end
	end

	// request and writeback address
	always_ff @(posedge clock_i) begin
		if (active) begin
			req_q <= cur_cmd;
			way_q <= tag_hit_i ? tag_hit_way_i : victim_way_i;
		end
		if (wb_push && (beat_q == '0)) begin
			wb_addr_q <= {victim_tag_i, cur_set, {l2_cache_pkg::BLOCK_W{1'b0}}};
		end
	end

endmodule

`default_nettype wire

//--- hw/l2_cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module l2_cache_top (
	input  wire                          clock_i,
	input  wire                          resetn_i,

	// l1 side
	input  wire                          l1_req_i,
	input  wire l2_cache_pkg::l1_cmd_t   l1_cmd_i,
	input  wire                          l1_wvalid_i,
	input  wire l2_cache_pkg::word_t     l1_wdata_i,
	input  wire                          l1_rready_i,
	output l2_cache_pkg::word_t          l1_rdata_o,
	output logic                         l1_rack_o,
	output logic                         l1_rvalid_o,
	output logic                         l1_done_o,

	// memory side
	input  wire                          mem_ready_i,
	output logic                         mem_req_o,
	output l2_cache_pkg::mem_cmd_t       mem_cmd_o,
	input  wire                          fill_ready_i,
	input  wire l2_cache_pkg::word_t     fill_data_i,
	output logic                         fill_ack_o,
	input  wire                          wb_ready_i,
	output logic                         wb_ack_o,
	output l2_cache_pkg::word_t          wb_data_o,

	output l2_cache_pkg::perf_t          perf_o
);

	// ------------------------------
	// internal nets
	// ------------------------------
	logic                      tag_hit;
	l2_cache_pkg::way_t        tag_hit_way;
	l2_cache_pkg::tag_t        victim_tag;
	l2_cache_pkg::way_t        victim_way;
	l2_cache_pkg::set_idx_t    tag_set;      // lookup and advance set
	l2_cache_pkg::tag_t        tag;
	logic                      tag_wren;
	l2_cache_pkg::way_t        tag_way;
	logic                      repl_adv;
	l2_cache_pkg::ram_addr_t   ram_addr;
	logic                      ram_wren;
	l2_cache_pkg::word_t       ram_wdata;

	l2_cache_controller u_ctrl (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.l1_req_i      (l1_req_i),
		.l1_cmd_i      (l1_cmd_i),
		.l1_wvalid_i   (l1_wvalid_i),
		.l1_wdata_i    (l1_wdata_i),
		.l1_rready_i   (l1_rready_i),
		.l1_rack_o     (l1_rack_o),
		.l1_rvalid_o   (l1_rvalid_o),
		.l1_done_o     (l1_done_o),
		.tag_hit_i     (tag_hit),
		.tag_hit_way_i (tag_hit_way),
		.victim_tag_i  (victim_tag),
		.victim_way_i  (victim_way),
		.tag_set_o     (tag_set),
		.tag_o         (tag),
		.tag_wren_o    (tag_wren),
		.tag_way_o     (tag_way),
		.repl_adv_o    (repl_adv),
		.ram_addr_o    (ram_addr),
		.ram_wren_o    (ram_wren),
		.ram_wdata_o   (ram_wdata),
		.ram_rdata_i   (l1_rdata_o),       // ram read data also feeds l1 directly
		.fill_ready_i  (fill_ready_i),
		.fill_data_i   (fill_data_i),
		.fill_ack_o    (fill_ack_o),
		.wb_ready_i    (wb_ready_i),
		.wb_ack_o      (wb_ack_o),
		.wb_data_o     (wb_data_o),
		.mem_ready_i   (mem_ready_i),
		.mem_req_o     (mem_req_o),
		.mem_cmd_o     (mem_cmd_o),
		.perf_o        (perf_o)
	);

	l2_tag_store u_tags (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.set_i        (tag_set),
		.tag_i        (tag),
		.wren_i       (tag_wren),
		.wr_way_i     (tag_way),
		.victim_way_i (victim_way),
		.hit_o        (tag_hit),
		.hit_way_o    (tag_hit_way),
		.victim_tag_o (victim_tag)
	);

	l2_data_ram u_ram (
		.clock_i (clock_i),
		.addr_i  (ram_addr),
		.wren_i  (ram_wren),
		.wdata_i (ram_wdata),
		.rdata_o (l1_rdata_o)
	);

	l2_fifo_replacement u_repl (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.set_i        (tag_set),
		.advance_i    (repl_adv),
		.adv_set_i    (tag_set),         // same set as the committing tag write
		.victim_way_o (victim_way)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clock_o,
	output logic resetn_o
);

	localparam int HALF_PERIOD  = 50;   // 100 ns clock
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DLY    = 10;   // same offset as the other dut inputs

	initial begin
		clock_o = 1'b0;
		forever begin
			#(HALF_PERIOD);
			clock_o = ~clock_o;
		end
	end

	// reset low for the first cycles
	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#(DRIVE_DLY);
		resetn_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/tb_l2_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l2_cache;

	localparam int DRIVE_DLY = 10;                         // after rising edge
	localparam int MAX_WAIT  = 500;                        // cycles per wait loop
	localparam int N_RANDOM  = 40;
	localparam int MEM_WORDS = 1 << l2_cache_pkg::WORD_ADDR_W;
	localparam int BW        = l2_cache_pkg::BLOCK_WORDS;
	localparam int WW        = l2_cache_pkg::WORD_W;

	typedef logic [BW*WW-1:0] block_t;                     // word 0 in the low bits

	logic                     clock;
	logic                     resetn;
	logic                     l1_req;
	l2_cache_pkg::l1_cmd_t    l1_cmd;
	logic                     l1_wvalid;
	l2_cache_pkg::word_t      l1_wdata;
	logic                     l1_rready;
	l2_cache_pkg::word_t      l1_rdata;
	logic                     l1_rack;
	logic                     l1_rvalid;
	logic                     l1_done;
	logic                     mem_ready;
	logic                     mem_req;
	l2_cache_pkg::mem_cmd_t   mem_cmd;
	logic                     fill_ready;
	l2_cache_pkg::word_t      fill_data;
	logic                     fill_ack;
	logic                     wb_ready;
	logic                     wb_ack;
	l2_cache_pkg::word_t      wb_data;
	l2_cache_pkg::perf_t      perf;

	// ------------------------------
	// memory model and scoreboard
	// ------------------------------
	l2_cache_pkg::word_t      mem_q [MEM_WORDS];           // what memory holds
	l2_cache_pkg::word_t      shadow [MEM_WORDS];          // latest data written by l1
	l2_cache_pkg::word_t      fill_q [$];
	l2_cache_pkg::word_t      exp_rd_q [$];
	l2_cache_pkg::word_t      wb_word_q [$];
	l2_cache_pkg::word_addr_t wb_addr_q [$];
	l2_cache_pkg::word_addr_t last_rd_addr;
	l2_cache_pkg::word_addr_t last_wr_addr;
	integer                   seed;
	string                    test_name = "reset";
	int n_errors = 0;
	int n_hit = 0;
	int n_miss = 0;
	int n_wb = 0;
	int n_rd_cmd = 0;
	int n_wr_cmd = 0;
	int n_rvalid = 0;
	int n_wb_blocks = 0;
	int hit0, miss0, wb0, rd0, wr0, blk0;

	tb_clock_gen clk_gen (
		.clock_o  (clock),
		.resetn_o (resetn)
	);

	l2_cache_top dut (
		.clock_i      (clock),
		.resetn_i     (resetn),
		.l1_req_i     (l1_req),
		.l1_cmd_i     (l1_cmd),
		.l1_wvalid_i  (l1_wvalid),
		.l1_wdata_i   (l1_wdata),
		.l1_rready_i  (l1_rready),
		.l1_rdata_o   (l1_rdata),
		.l1_rack_o    (l1_rack),
		.l1_rvalid_o  (l1_rvalid),
		.l1_done_o    (l1_done),
		.mem_ready_i  (mem_ready),
		.mem_req_o    (mem_req),
		.mem_cmd_o    (mem_cmd),
		.fill_ready_i (fill_ready),
		.fill_data_i  (fill_data),
		.fill_ack_o   (fill_ack),
		.wb_ready_i   (wb_ready),
		.wb_ack_o     (wb_ack),
		.wb_data_o    (wb_data),
		.perf_o       (perf)
	);

	// initial memory image, whole address mixed in
	function automatic l2_cache_pkg::word_t mem_word(input l2_cache_pkg::word_addr_t addr);
		mem_word = $random(seed) ^ {addr, 8'h5a, addr};
	endfunction

	function automatic l2_cache_pkg::word_addr_t block_base(input l2_cache_pkg::word_addr_t a);
		block_base = {a[l2_cache_pkg::WORD_ADDR_W-1:l2_cache_pkg::BLOCK_W],
		              {l2_cache_pkg::BLOCK_W{1'b0}}};
	endfunction

	task automatic check(input string what, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (expected !== actual) begin
			n_errors++;
			$display("FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_with_error(input string msg);
		n_errors++;
		$display("ERROR in %s: %s", test_name, msg);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	// until l1_done is seen high, then to the drive point
	task automatic wait_idle();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (l1_done !== 1'b1) begin
			cycles++;
			if (cycles > MAX_WAIT) begin
				stop_with_error("l1_done_o stayed low");
			end
			@(negedge clock);
		end
		@(posedge clock);
		#(DRIVE_DLY);
	endtask

	task automatic issue_req(input l2_cache_pkg::word_addr_t addr, input logic rw);
		wait_idle();
		l1_req      = 1'b1;                 // one cycle only
		l1_cmd.addr = addr;
		l1_cmd.rw   = rw;
		@(posedge clock);
		#(DRIVE_DLY);
		l1_req = 1'b0;
	endtask

	task automatic read_block(input l2_cache_pkg::word_addr_t addr);
		l2_cache_pkg::word_addr_t base;
		int seen;
		base = block_base(addr);
		for (int k = 0; k < BW; k++) begin
			exp_rd_q.push_back(shadow[base + k]);
		end
		seen = n_rvalid;
		issue_req(addr, 1'b0);
		wait_idle();
		check("read beats", BW, n_rvalid - seen);
	endtask

	task automatic write_block(input l2_cache_pkg::word_addr_t addr, input block_t data);
		l2_cache_pkg::word_addr_t base;
		int beat;
		int cycles;
		base = block_base(addr);
		for (int k = 0; k < BW; k++) begin
			shadow[base + k] = data[WW*k +: WW];
		end
		issue_req(addr, 1'b1);
		beat      = 0;
		l1_wvalid = 1'b1;
		l1_wdata  = data[WW-1:0];
		while (beat < BW) begin
			cycles = 0;
			@(negedge clock);
			while (l1_rack !== 1'b1) begin
				cycles++;
				if (cycles > MAX_WAIT) begin
					stop_with_error("write word never taken");
				end
				@(negedge clock);
			end
			@(posedge clock);
			#(DRIVE_DLY);
			beat++;
			if (beat < BW) begin
				l1_wdata = data[WW*beat +: WW];     // next word after the ack
			end
		end
		l1_wvalid = 1'b0;
		wait_idle();
	endtask

	task automatic save_counts();
		hit0 = n_hit;
		miss0 = n_miss;
		wb0 = n_wb;
		rd0 = n_rd_cmd;
		wr0 = n_wr_cmd;
		blk0 = n_wb_blocks;
	endtask

	task automatic expect_counts(input int hit, input int miss, input int wb,
	                             input int rd, input int wr);
		check("hit pulses", hit, n_hit - hit0);
		check("miss pulses", miss, n_miss - miss0);
		check("writeback pulses", wb, n_wb - wb0);
		check("block read commands", rd, n_rd_cmd - rd0);
		check("block write commands", wr, n_wr_cmd - wr0);
		check("writeback blocks", wr, n_wb_blocks - blk0);
	endtask

	// ------------------------------
	// memory model
	// ------------------------------
	always @(negedge clock) begin : mem_model
		l2_cache_pkg::word_addr_t base;
		if (mem_req === 1'b1 && !mem_cmd.rw) begin
			base = mem_cmd.addr;
			for (int k = 0; k < BW; k++) begin
				fill_q.push_back(mem_q[base + k]);   // whole block at once
			end
		end
		if (fill_ack === 1'b1) begin
			if (fill_q.size() == 0) begin
				stop_with_error("fill word taken from an empty buffer");
			end else begin
				fill_q.delete(0);
			end
		end
	end

	// buffer levels, driven like every other input
	initial begin
		mem_ready  = 1'b1;
		wb_ready   = 1'b1;
		fill_ready = 1'b0;
		fill_data  = '0;
		forever begin
			@(posedge clock);
			#(DRIVE_DLY);
			if (fill_q.size() > 0) begin
				fill_ready = 1'b1;
				fill_data  = fill_q[0];
			end else begin
				fill_ready = 1'b0;
				fill_data  = '0;
			end
		end
	end

	// ------------------------------
	// compare
	// ------------------------------
	always @(negedge clock) begin : compare
		l2_cache_pkg::word_addr_t base;
		l2_cache_pkg::word_t      word;
		if (l1_rvalid === 1'b1) begin
			n_rvalid++;
			if (exp_rd_q.size() == 0) begin
				stop_with_error("read data with no read pending");
			end else begin
				check("read data", exp_rd_q.pop_front(), l1_rdata);
			end
		end
		if (perf.hit === 1'b1) n_hit++;
		if (perf.miss === 1'b1) n_miss++;
		if (perf.writeback === 1'b1) n_wb++;
		if (mem_req === 1'b1) begin
			check("command block flag", 1, mem_cmd.block);
			if (mem_cmd.rw) begin
				n_wr_cmd++;
				last_wr_addr = mem_cmd.addr;
				wb_addr_q.push_back(mem_cmd.addr);   // usually after the first word
			end else begin
				n_rd_cmd++;
				last_rd_addr = mem_cmd.addr;
			end
		end
		if (wb_ack === 1'b1) begin
			wb_word_q.push_back(wb_data);
		end
		// full block with its address, check then store in memory
		if (wb_word_q.size() >= BW && wb_addr_q.size() > 0) begin
			base = wb_addr_q.pop_front();
			for (int k = 0; k < BW; k++) begin
				word = wb_word_q.pop_front();
				check("writeback data", shadow[base + k], word);
				mem_q[base + k] = word;
			end
			n_wb_blocks++;
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin : main
		int                       cycles;
		logic [31:0]              r;
		l2_cache_pkg::word_addr_t addr;
		l2_cache_pkg::tag_t       tag;
		block_t                   data;
		seed      = 32'h892a;
		l1_req    = 1'b0;
		l1_cmd    = '0;
		l1_wvalid = 1'b0;
		l1_wdata  = '0;
		l1_rready = 1'b1;                       // l1 always takes read data
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem_q[a]  = mem_word(l2_cache_pkg::word_addr_t'(a));
			shadow[a] = mem_q[a];
		end

		cycles = 0;
		@(negedge clock);
		while (resetn !== 1'b1) begin
			cycles++;
			if (cycles > MAX_WAIT) begin
				stop_with_error("reset never released");
			end
			@(negedge clock);
		end

		test_name = "read_miss";                // set 0, unaligned request
		save_counts();
		read_block(12'h041);
		expect_counts(0, 1, 0, 1, 0);
		check("fill address", 12'h040, last_rd_addr);

		test_name = "read_hit";
		save_counts();
		read_block(12'h042);
		expect_counts(1, 0, 0, 0, 0);

		test_name = "write_hit";
		save_counts();
		write_block(12'h040, {32'hc0de_0003, 32'hc0de_0002, 32'hc0de_0001, 32'hc0de_0000});
		read_block(12'h043);
		expect_counts(2, 0, 0, 0, 0);

		test_name = "write_miss";               // set 1, no fetch
		save_counts();
		write_block(12'h054, {32'h5eed_0013, 32'h5eed_0012, 32'h5eed_0011, 32'h5eed_0010});
		expect_counts(0, 1, 0, 0, 0);
		save_counts();
		read_block(12'h056);
		expect_counts(1, 0, 0, 0, 0);

		test_name = "dirty_eviction";           // set 2, ways fill 0 then 1
		write_block(12'h108, {32'hd1d1_0003, 32'hd1d1_0002, 32'hd1d1_0001, 32'hd1d1_0000});
		read_block(12'h208);
		save_counts();
		read_block(12'h308);                    // evicts the dirty 0x108 block
		expect_counts(0, 1, 1, 1, 1);
		check("writeback address", 12'h108, last_wr_addr);
		save_counts();
		read_block(12'h10a);                    // back from memory, clean victim
		expect_counts(0, 1, 0, 1, 0);

		test_name = "random";
		for (int i = 0; i < N_RANDOM; i++) begin
			r    = $random(seed);
			tag  = 8'h40 + r[3:2];              // 16 blocks, 4 tags per set
			addr = {tag, r[1:0], r[5:4]};
			if (r[8]) begin
				data = {$random(seed), $random(seed), $random(seed), $random(seed)};
				write_block(addr, data);
			end else begin
				read_block(addr);
			end
		end

		test_name = "end";
		check("reads left pending", 0, exp_rd_q.size());
		check("writeback words left over", 0, wb_word_q.size());
		check("writeback commands left over", 0, wb_addr_q.size());
		if (n_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/l2_cache_pkg.sv
hw/l2_tag_store.sv
hw/l2_data_ram.sv
hw/l2_fifo_replacement.sv
hw/l2_cache_controller.sv
hw/l2_cache_top.sv
dv/tb_clock_gen.sv
dv/tb_l2_cache.sv

//--- Bender.yml
package:
  name: l2_cache

sources:
  - hw/l2_cache_pkg.sv
  - hw/l2_tag_store.sv
  - hw/l2_data_ram.sv
  - hw/l2_fifo_replacement.sv
  - hw/l2_cache_controller.sv
  - hw/l2_cache_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_l2_cache.sv
